// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // field positions inside a 32-bit instruction
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int ALT_BIT    = 30;   // funct7[5], picks SUB and SRA

    // major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B          // operand b straight through, for LUI
    } alu_op_e;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LINK = 2'd1      // pc plus 4
    } wb_sel_e;

endpackage

`default_nettype wire

// File: src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        logic [31:0]           rs1_data;
        logic [31:0]           rs2_data;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [31:0]           imm;
        rv_isa_pkg::alu_op_e   alu_op;
        logic                  a_is_pc;    // operand a from pc instead of rs1
        logic                  b_is_imm;   // operand b from imm instead of rs2
        logic                  is_branch;
        rv_isa_pkg::branch_e   branch_cond;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  reg_write;
        rv_isa_pkg::wb_sel_e   wb_sel;
    } id_ex_t;

    // execute to result
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        logic [4:0]            rd;
        logic                  reg_write;
        rv_isa_pkg::wb_sel_e   wb_sel;
        logic [31:0]           alu_result;
        logic [31:0]           link;
    } ex_wb_t;

    // one retired instruction, seen by the testbench
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] data;
    } retire_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_write_t;

endpackage

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter int          IMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   redirect_i,
    input  logic [31:0]            target_i,
    output logic [31:0]            pc_o,
    output logic                   fetch_valid_o,
    output logic [IMEM_AWIDTH-1:0] imem_addr_o
);

    logic [31:0] pc_q;
    logic [31:0] next_pc;
    logic        boot_q;   // high for one cycle after reset

    // hold the pc while booting so the memory output catches up with it
    always_comb begin
        if (redirect_i) begin
            next_pc = target_i;
        end else if (boot_q) begin
            next_pc = pc_q;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q   <= RESET_PC;
            boot_q <= 1'b1;
        end else begin
            pc_q   <= next_pc;
            boot_q <= 1'b0;
        end
    end

    assign imem_addr_o   = next_pc[IMEM_AWIDTH+1:2];   // word address
    assign pc_o          = pc_q;
    assign fetch_valid_o = ~boot_q;   // memory word matches pc_q

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [31:0]      instr_i,
    input  logic [31:0]      pc_i,
    input  logic             fetch_valid_i,
    input  logic             flush_i,
    output logic [4:0]       rs1_o,
    output logic [4:0]       rs2_o,
    input  logic [31:0]      rs1_data_i,
    input  logic [31:0]      rs2_data_i,
    output pipe_pkg::id_ex_t id_ex_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic                alt;
    logic [4:0]          rd;
    logic [31:0]         imm_i;
    logic [31:0]         imm_u;
    logic [31:0]         imm_j;
    logic [31:0]         imm_b;
    pipe_pkg::id_ex_t    id_ex_d;
    pipe_pkg::id_ex_t    id_ex_q;

    // register and immediate forms share the funct3 map
    function automatic rv_isa_pkg::alu_op_e alu_decode(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       is_reg
    );
        rv_isa_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt_bit) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            3'b001:  op = rv_isa_pkg::ALU_SLL;
            3'b010:  op = rv_isa_pkg::ALU_SLT;
            3'b011:  op = rv_isa_pkg::ALU_SLTU;
            3'b100:  op = rv_isa_pkg::ALU_XOR;
            3'b101:  op = alt_bit ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110:  op = rv_isa_pkg::ALU_OR;
            default: op = rv_isa_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_isa_pkg::opcode_e'(instr_i[rv_isa_pkg::OPCODE_W-1:0]);
    assign funct3 = instr_i[rv_isa_pkg::FUNCT3_LSB +: 3];
    assign alt    = instr_i[rv_isa_pkg::ALT_BIT];
    assign rd     = instr_i[rv_isa_pkg::RD_LSB +: 5];
    assign rs1_o  = instr_i[rv_isa_pkg::RS1_LSB +: 5];
    assign rs2_o  = instr_i[rv_isa_pkg::RS2_LSB +: 5];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        id_ex_d             = '0;
        id_ex_d.valid       = fetch_valid_i & ~flush_i;   // squash on a taken redirect
        id_ex_d.pc          = pc_i;
        id_ex_d.rs1_data    = rs1_data_i;
        id_ex_d.rs2_data    = rs2_data_i;
        id_ex_d.rs1         = rs1_o;
        id_ex_d.rs2         = rs2_o;
        id_ex_d.rd          = rd;
        id_ex_d.imm         = imm_i;
        id_ex_d.alu_op      = rv_isa_pkg::ALU_ADD;
        id_ex_d.branch_cond = rv_isa_pkg::branch_e'(funct3);
        id_ex_d.wb_sel      = rv_isa_pkg::WB_ALU;

        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                id_ex_d.alu_op    = alu_decode(funct3, alt, 1'b1);
                id_ex_d.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                id_ex_d.alu_op    = alu_decode(funct3, alt, 1'b0);
                id_ex_d.b_is_imm  = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                id_ex_d.imm       = imm_u;
                id_ex_d.alu_op    = rv_isa_pkg::ALU_PASS_B;
                id_ex_d.b_is_imm  = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                id_ex_d.imm       = imm_u;
                id_ex_d.a_is_pc   = 1'b1;
                id_ex_d.b_is_imm  = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                id_ex_d.imm       = imm_j;
                id_ex_d.is_jal    = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.wb_sel    = rv_isa_pkg::WB_LINK;
            end
            rv_isa_pkg::OPC_JALR: begin
                id_ex_d.is_jalr   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.wb_sel    = rv_isa_pkg::WB_LINK;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = (funct3[2:1] != 2'b01);   // 010 and 011 are not branches
            end
            default: ;   // unknown opcode retires with no write
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
        if (reset_i) begin
            id_ex_q.valid <= 1'b0;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  pipe_pkg::id_ex_t    id_ex_i,
    input  pipe_pkg::rf_write_t fwd_i,
    output logic                redirect_o,
    output logic [31:0]         target_o,
    output pipe_pkg::ex_wb_t    ex_wb_o
);

    logic [31:0]      rs1_val;
    logic [31:0]      rs2_val;
    logic [31:0]      op_a;
    logic [31:0]      op_b;
    logic [4:0]       shamt;
    logic [31:0]      alu_result;
    logic             cond_true;
    logic             taken;
    logic [31:0]      jalr_sum;
    pipe_pkg::ex_wb_t ex_wb_d;
    pipe_pkg::ex_wb_t ex_wb_q;

    // the instruction in result writes this cycle, take its value
    always_comb begin
        rs1_val = id_ex_i.rs1_data;
        rs2_val = id_ex_i.rs2_data;
        if (fwd_i.we && fwd_i.addr != 5'd0 && fwd_i.addr == id_ex_i.rs1) begin
            rs1_val = fwd_i.data;
        end
        if (fwd_i.we && fwd_i.addr != 5'd0 && fwd_i.addr == id_ex_i.rs2) begin
            rs2_val = fwd_i.data;
        end
    end

    assign op_a  = id_ex_i.a_is_pc ? id_ex_i.pc : rs1_val;
    assign op_b  = id_ex_i.b_is_imm ? id_ex_i.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_result = op_a + op_b;
            rv_isa_pkg::ALU_SUB:    alu_result = op_a - op_b;
            rv_isa_pkg::ALU_AND:    alu_result = op_a & op_b;
            rv_isa_pkg::ALU_OR:     alu_result = op_a | op_b;
            rv_isa_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
            rv_isa_pkg::ALU_SLL:    alu_result = op_a << shamt;
            rv_isa_pkg::ALU_SRL:    alu_result = op_a >> shamt;
            rv_isa_pkg::ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_isa_pkg::ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
            rv_isa_pkg::ALU_PASS_B: alu_result = op_b;
            default:                alu_result = 32'b0;
        endcase
    end

    // branch compare always works on the register operands
    always_comb begin
        case (id_ex_i.branch_cond)
            rv_isa_pkg::BR_EQ:  cond_true = (rs1_val == rs2_val);
            rv_isa_pkg::BR_NE:  cond_true = (rs1_val != rs2_val);
            rv_isa_pkg::BR_LT:  cond_true = ($signed(rs1_val) < $signed(rs2_val));
            rv_isa_pkg::BR_GE:  cond_true = ($signed(rs1_val) >= $signed(rs2_val));
            rv_isa_pkg::BR_LTU: cond_true = (rs1_val < rs2_val);
            rv_isa_pkg::BR_GEU: cond_true = (rs1_val >= rs2_val);
            default:            cond_true = 1'b0;
        endcase
    end

    assign taken = (id_ex_i.is_branch && cond_true) || id_ex_i.is_jal || id_ex_i.is_jalr;
    assign redirect_o = id_ex_i.valid && taken;

    assign jalr_sum = rs1_val + id_ex_i.imm;
    assign target_o = id_ex_i.is_jalr ? {jalr_sum[31:1], 1'b0}
                                      : id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        ex_wb_d.valid      = id_ex_i.valid;
        ex_wb_d.pc         = id_ex_i.pc;
        ex_wb_d.rd         = id_ex_i.rd;
        ex_wb_d.reg_write  = id_ex_i.reg_write;
        ex_wb_d.wb_sel     = id_ex_i.wb_sel;
        ex_wb_d.alu_result = alu_result;
        ex_wb_d.link       = id_ex_i.pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        ex_wb_q <= ex_wb_d;
        if (reset_i) begin
            ex_wb_q.valid <= 1'b0;
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

`default_nettype wire

// File: src/result_stage.sv
`default_nettype none

// purely combinational, so the write and the retire land on the same edge
module result_stage (
    input  pipe_pkg::ex_wb_t    ex_wb_i,
    output pipe_pkg::rf_write_t rf_write_o,
    output pipe_pkg::retire_t   retire_o
);

    logic [31:0] wb_data;
    logic        wr_en;

    always_comb begin
        case (ex_wb_i.wb_sel)
            rv_isa_pkg::WB_LINK: wb_data = ex_wb_i.link;
            default:             wb_data = ex_wb_i.alu_result;
        endcase
    end

    // x0 is never written
    assign wr_en = ex_wb_i.valid && ex_wb_i.reg_write && (ex_wb_i.rd != 5'd0);

    always_comb begin
        rf_write_o.we   = wr_en;
        rf_write_o.addr = ex_wb_i.rd;
        rf_write_o.data = wb_data;
    end

    always_comb begin
        retire_o.valid = ex_wb_i.valid;
        retire_o.pc    = ex_wb_i.pc;
        retire_o.rd    = ex_wb_i.rd;
        retire_o.we    = wr_en;
        retire_o.data  = wb_data;
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [4:0]          ra1_i,
    input  logic [4:0]          ra2_i,
    output logic [31:0]         rd1_o,
    output logic [31:0]         rd2_o,
    input  pipe_pkg::rf_write_t wr_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wr_i.we && wr_i.addr != 5'd0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // write-through covers the instruction two behind the writer
    assign rd1_o = (ra1_i == 5'd0) ? 32'b0 :
                   (wr_i.we && wr_i.addr == ra1_i) ? wr_i.data : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? 32'b0 :
                   (wr_i.we && wr_i.addr == ra2_i) ? wr_i.data : regs[ra2_i];

endmodule

`default_nettype wire

// File: src/core_top.sv
`default_nettype none

module core_top #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter int          IMEM_AWIDTH = 10
) (
    input  logic                   clk,
    input  logic                   reset_i,
    output logic [IMEM_AWIDTH-1:0] imem_addr_o,
    input  logic [31:0]            imem_data_i,
    output pipe_pkg::retire_t      retire_o
);

    logic [31:0]         pc;
    logic                fetch_valid;
    logic                redirect;
    logic [31:0]         target;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [31:0]         rs1_data;
    logic [31:0]         rs2_data;
    pipe_pkg::id_ex_t    id_ex;
    pipe_pkg::ex_wb_t    ex_wb;
    pipe_pkg::rf_write_t rf_write;   // also the forwarding path into execute

    fetch_unit #(
        .RESET_PC   (RESET_PC),
        .IMEM_AWIDTH(IMEM_AWIDTH)
    ) fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .redirect_i   (redirect),
        .target_i     (target),
        .pc_o         (pc),
        .fetch_valid_o(fetch_valid),
        .imem_addr_o  (imem_addr_o)
    );

    decode_stage decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .instr_i      (imem_data_i),
        .pc_i         (pc),
        .fetch_valid_i(fetch_valid),
        .flush_i      (redirect),
        .rs1_o        (rs1_addr),
        .rs2_o        (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .id_ex_o      (id_ex)
    );

    execute_stage execute (
        .clk       (clk),
        .reset_i   (reset_i),
        .id_ex_i   (id_ex),
        .fwd_i     (rf_write),
        .redirect_o(redirect),
        .target_o  (target),
        .ex_wb_o   (ex_wb)
    );

    result_stage result (
        .ex_wb_i   (ex_wb),
        .rf_write_o(rf_write),
        .retire_o  (retire_o)
    );

    reg_file rf (
        .clk    (clk),
        .reset_i(reset_i),
        .ra1_i  (rs1_addr),
        .ra2_i  (rs2_addr),
        .rd1_o  (rs1_data),
        .rd2_o  (rs2_data),
        .wr_i   (rf_write)
    );

endmodule

`default_nettype wire

// File: verif/core_checker.sv
`default_nettype none

module core_checker (
    input logic              clk,
    input logic              reset_i,
    input logic              redirect_i,
    input pipe_pkg::retire_t retire_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // pipeline is empty right after any reset cycle
    assert property (@(posedge clk) reset_i |=> !retire_i.valid)
        else $error("retire valid in the cycle after reset");

    // the taken instruction retires next, the squashed one leaves a bubble
    assert property (@(posedge clk) disable iff (reset_i)
        redirect_i |=> retire_i.valid ##1 !retire_i.valid)
        else $error("no bubble two cycles after a taken redirect");

    assert property (@(posedge clk) disable iff (reset_i)
        retire_i.we |-> retire_i.rd != 5'd0)
        else $error("register write retired with rd equal to x0");

endmodule

bind core_top core_checker core_chk (
    .clk       (clk),
    .reset_i   (reset_i),
    .redirect_i(redirect),
    .retire_i  (retire_o)
);

`default_nettype wire

// File: verif/core_tb.sv
`default_nettype none

module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC    = 32'h0000_0040;
    localparam int          IMEM_AWIDTH = 8;
    localparam int          ROM_WORDS   = 1 << IMEM_AWIDTH;
    localparam int          PROG_LEN    = 200;
    localparam int          RUN_LEN     = 300;               // retirements checked
    localparam int          TIMEOUT     = 2 * RUN_LEN + 50;  // at most one bubble each

    logic                   clk;
    logic                   reset_i;
    logic [IMEM_AWIDTH-1:0] imem_addr;
    logic [31:0]            imem_data;
    pipe_pkg::retire_t      retire;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] rng;
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    int          cycles;
    int          retired;
    int          checks;
    int          errors;

    core_top #(
        .RESET_PC   (RESET_PC),
        .IMEM_AWIDTH(IMEM_AWIDTH)
    ) uut (
        .clk        (clk),
        .reset_i    (reset_i),
        .imem_addr_o(imem_addr),
        .imem_data_i(imem_data),
        .retire_o   (retire)
    );

    always #2 clk = ~clk;

    // synchronous ROM, address taken at the edge, data out 1 ns later
    always @(posedge clk) begin
        imem_data <= #1 rom[imem_addr];
        cycles    <= cycles + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input rv_isa_pkg::opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input rv_isa_pkg::opcode_e opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    task automatic store_word(input int idx, input logic [31:0] w);
        rom[idx[IMEM_AWIDTH-1:0]] = w;
    endtask

    // random straight-line code, every branch and jump goes forward
    task automatic build_program();
        int          idx;
        int          last;
        int          off;
        int          target;
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int i = 0; i < ROM_WORDS; i++) begin
            store_word(i, {i[24:0], 7'b0000000});   // opcode 0 is unsupported
        end
        idx  = int'(RESET_PC >> 2);
        last = idx + PROG_LEN - 1;
        while (idx < last) begin
            r   = next_rand();
            v   = next_rand();
            rd  = {2'b00, r[2:0]};   // x0..x7 keeps dependencies close
            rs1 = {2'b00, r[5:3]};
            rs2 = {2'b00, r[8:6]};
            f3  = r[11:9];
            imm = v[11:0];
            off = 1 + int'(r[25:24]);
            if (idx + off > last) begin
                off = last - idx;
            end
            case (r[31:28])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    store_word(idx, r_type(((f3 == 3'b000 || f3 == 3'b101) && r[26]) ? 7'h20
                                                                                    : 7'h00,
                                           rs2, rs1, f3, rd));
                end
                4'd4, 4'd5, 4'd6: begin
                    if (f3 == 3'b001) begin
                        imm = {7'h00, v[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm = {r[26] ? 7'h20 : 7'h00, v[4:0]};   // srai or srli
                    end
                    store_word(idx, i_type(imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM));
                end
                4'd7: store_word(idx, u_type(v[31:12], rd, rv_isa_pkg::OPC_LUI));
                4'd8: store_word(idx, u_type(v[31:12], rd, rv_isa_pkg::OPC_AUIPC));
                4'd9, 4'd10, 4'd11, 4'd12: begin
                    if (f3[2:1] == 2'b01) begin
                        f3[2] = 1'b1;   // 010 and 011 are no branch
                    end
                    // same register on both sides gives a known outcome
                    store_word(idx, b_type(13'(off * 4), r[27] ? rs1 : rs2, rs1, f3));
                end
                4'd13: store_word(idx, j_type(21'(off * 4), rd));
                4'd14: begin
                    if (idx + 1 < last) begin
                        if (rs1 == 5'd0) begin
                            rs1 = 5'd1;
                        end
                        if (idx + 1 + off > last) begin
                            off = last - idx - 1;
                        end
                        target = (idx + 1 + off) * 4;
                        // odd base now and then, bit 0 must drop
                        store_word(idx, i_type(12'(target - 4 + int'(r[26])), 5'd0, 3'b000,
                                               rs1, rv_isa_pkg::OPC_OP_IMM));
                        store_word(idx + 1, i_type(12'd4, rs1, 3'b000, rd,
                                                   rv_isa_pkg::OPC_JALR));
                        idx++;
                    end else begin
                        store_word(idx, i_type(imm, rs1, 3'b000, rd, rv_isa_pkg::OPC_OP_IMM));
                    end
                end
                default: store_word(idx, {v[31:7], 7'b0000011});   // a load, not supported
            endcase
            idx++;
        end
        store_word(last, j_type(21'd0, 5'd0));   // spin here
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b,
                                            input logic is_reg);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: return (is_reg && alt) ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction on the architectural state
    function automatic pipe_pkg::retire_t ref_step(input logic [31:0] regs [32],
                                                   input logic [31:0] pc,
                                                   input logic [31:0] instr,
                                                   output logic [31:0] next_pc);
        pipe_pkg::retire_t exp;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       imm_i;
        logic [31:0]       imm_b;
        logic [31:0]       imm_j;
        logic [31:0]       res;
        logic              wr;
        logic              take;
        a       = regs[instr[19:15]];
        b       = regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        res     = 32'd0;
        wr      = 1'b0;
        take    = 1'b0;
        next_pc = pc + 32'd4;
        case (instr[6:0])
            rv_isa_pkg::OPC_OP: begin
                wr  = 1'b1;
                res = alu_ref(instr[14:12], instr[30], a, b, 1'b1);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                wr  = 1'b1;
                res = alu_ref(instr[14:12], instr[30], a, imm_i, 1'b0);
            end
            rv_isa_pkg::OPC_LUI: begin
                wr  = 1'b1;
                res = {instr[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_AUIPC: begin
                wr  = 1'b1;
                res = pc + {instr[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_JAL: begin
                wr      = 1'b1;
                res     = pc + 32'd4;
                next_pc = pc + imm_j;
            end
            rv_isa_pkg::OPC_JALR: begin
                wr      = 1'b1;
                res     = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (instr[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = pc + imm_b;
                end
            end
            default: ;   // unsupported, no write
        endcase
        exp.valid = 1'b1;
        exp.pc    = pc;
        exp.rd    = instr[11:7];
        exp.we    = wr && (instr[11:7] != 5'd0);
        exp.data  = exp.we ? res : 32'd0;
        return exp;
    endfunction

    task automatic compare_retire(input string name, input pipe_pkg::retire_t exp,
                                  input pipe_pkg::retire_t act);
        checks++;
        if (act.rd !== exp.rd || act.we !== exp.we || (exp.we && act.data !== exp.data)) begin
            errors++;
            $display("error %s: expected rd=%0d we=%0b data=%h, actual rd=%0d we=%0b data=%h",
                     name, exp.rd, exp.we, exp.data, act.rd, act.we, act.data);
        end
    endtask

    task automatic compare_pc(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // outputs settle after the rising edge, sample in the middle of the cycle
    always @(negedge clk) begin
        pipe_pkg::retire_t exp;
        logic [31:0]       npc;
        if (!reset_i && retire.valid) begin
            exp = ref_step(model_regs, model_pc, rom[model_pc[IMEM_AWIDTH+1:2]], npc);
            compare_pc($sformatf("pc of retirement %0d", retired), model_pc, retire.pc);
            compare_retire($sformatf("retirement %0d at %h", retired, model_pc), exp, retire);
            if (exp.we) begin
                model_regs[exp.rd] = exp.data;
            end
            model_pc = npc;
            retired++;
        end
    end

    initial begin
        clk        = 1'b0;
        reset_i    = 1'b1;
        imem_data  = 32'd0;
        rng        = 32'h4a3c_3fce;
        cycles     = 0;
        retired    = 0;
        checks     = 0;
        errors     = 0;
        model_pc   = RESET_PC;
        model_regs = '{default: 32'd0};
        build_program();
        repeat (3) @(posedge clk);
        #1 reset_i = 1'b0;
        while (retired < RUN_LEN && cycles < TIMEOUT) begin
            @(posedge clk);
        end
        if (retired < RUN_LEN) begin
            errors++;
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, retired, RUN_LEN);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/rv_isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/reg_file.sv
src/core_top.sv
verif/core_checker.sv
verif/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator, pass only on the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
